// File: hdl/cdp_rdma_ig_pkg.sv
// shared widths, cube constants, context entry layout and layer state enum
package cdp_rdma_ig_pkg;

  // ==============================
  // widths and sizes
  // ==============================
  localparam int addr_w      = 64;
  localparam int stride_w    = 32;
  // width, height and channel register fields
  localparam int dim_w       = 13;
  // 32-byte atom
  localparam int atom_log2   = 5;
  localparam int group_atoms = 8;
  localparam int size_w      = 15;
  localparam int grp_cnt_w   = 11;
  // channel blocks of 32 channels
  localparam int chn_cnt_w   = dim_w - atom_log2;
  // request payload, address low and size high
  localparam int req_pd_w    = addr_w + size_w;
  localparam int cq_pd_w     = 6;

  // ==============================
  // context entry layout
  // ==============================
  // size takes bits 2..0
  localparam int cq_size_lsb   = 0;
  localparam int cq_last_w_bit = 3;
  localparam int cq_last_h_bit = 4;
  localparam int cq_last_c_bit = 5;

  // stall counter
  localparam int perf_w = 32;

  // layer control
  typedef enum logic [1:0] {
    st_idle      = 2'd0,
    st_run       = 2'd1,
    st_wait_done = 2'd2
  } layer_state_t;

endpackage

// File: hdl/cdp_rdma_cube_walker.sv
// layer FSM, W/C/H cube counters, position flags and request size
module cdp_rdma_cube_walker (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic                                 op_en,
  input  logic                                 eg2ig_done,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    width,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    height,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    channel,
  input  logic                                 accept,
  output logic                                 run,
  output logic                                 op_load,
  output logic                                 is_last_w,
  output logic                                 is_last_h,
  output logic                                 is_last_c,
  output logic [2:0]                           req_size,
  output logic                                 layer_end
);

  cdp_rdma_ig_pkg::layer_state_t state;
  cdp_rdma_ig_pkg::layer_state_t state_nxt;

  logic [cdp_rdma_ig_pkg::chn_cnt_w-1:0] chn_cnt;
  logic [cdp_rdma_ig_pkg::grp_cnt_w-1:0] grp_cnt;
  logic [cdp_rdma_ig_pkg::dim_w-1:0]     line_cnt;
  logic [cdp_rdma_ig_pkg::dim_w:0]       atoms;
  logic [cdp_rdma_ig_pkg::grp_cnt_w-1:0] num_grp;
  logic [cdp_rdma_ig_pkg::grp_cnt_w-1:0] grp_last;
  logic                                  is_first_w;
  logic                                  one_grp;

  // ==============================
  // layer control
  // ==============================
  // load only from idle, so a layer always starts clean
  assign op_load   = op_en & (state == cdp_rdma_ig_pkg::st_idle);
  assign run       = (state == cdp_rdma_ig_pkg::st_run);
  // cube end accepted
  assign layer_end = accept & is_last_c & is_last_w & is_last_h;

  always_comb begin
    state_nxt = state;
    case (state)
      cdp_rdma_ig_pkg::st_idle: begin
        if (op_en) begin
          state_nxt = cdp_rdma_ig_pkg::st_run;
        end
      end
      cdp_rdma_ig_pkg::st_run: begin
        if (layer_end) begin
          state_nxt = cdp_rdma_ig_pkg::st_wait_done;
        end
      end
      cdp_rdma_ig_pkg::st_wait_done: begin
        // egress drained the layer
        if (eg2ig_done) begin
          state_nxt = cdp_rdma_ig_pkg::st_idle;
        end
      end
      default: state_nxt = cdp_rdma_ig_pkg::st_idle;
    endcase
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= cdp_rdma_ig_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ==============================
  // cube counters, C then W then H
  // ==============================
  // width field is atoms minus one
  assign atoms   = {1'b0, width} + 1'b1;
  // groups of eight atoms, rounded up
  assign num_grp = atoms[cdp_rdma_ig_pkg::dim_w:$clog2(cdp_rdma_ig_pkg::group_atoms)]
                 + {{(cdp_rdma_ig_pkg::grp_cnt_w-1){1'b0}},
                    |atoms[$clog2(cdp_rdma_ig_pkg::group_atoms)-1:0]};
  assign grp_last = num_grp - 1'b1;

  // channel field is channels minus one, upper bits give the last block
  assign is_last_c  = (chn_cnt == channel[cdp_rdma_ig_pkg::dim_w-1:cdp_rdma_ig_pkg::atom_log2]);
  assign is_last_w  = (grp_cnt == grp_last);
  assign is_last_h  = (line_cnt == height);
  assign is_first_w = (grp_cnt == '0);
  assign one_grp    = (grp_last == '0);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      chn_cnt  <= '0;
      grp_cnt  <= '0;
      line_cnt <= '0;
    end else if (op_load) begin
      chn_cnt  <= '0;
      grp_cnt  <= '0;
      line_cnt <= '0;
    end else if (accept) begin
      // innermost, channel block
      chn_cnt <= is_last_c ? '0 : chn_cnt + 1'b1;
      // next width group after the last channel block
      if (is_last_c) begin
        grp_cnt <= is_last_w ? '0 : grp_cnt + 1'b1;
      end
      // next line after the whole slice
      if (is_last_c && is_last_w) begin
        line_cnt <= is_last_h ? '0 : line_cnt + 1'b1;
      end
    end
  end

  // ==============================
  // request size, atoms minus one
  // ==============================
  // a single group counts as the first one
  always_comb begin
    if (is_first_w) begin
      req_size = one_grp ? width[2:0] : 3'd7;
    end else if (is_last_w) begin
      req_size = width[2:0];
    end else begin
      req_size = 3'd7;
    end
  end

endmodule

// File: hdl/cdp_rdma_addr_gen.sv
// line base, group base and request address registers of the cube walk
module cdp_rdma_addr_gen (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic                                 op_load,
  input  logic                                 accept,
  input  logic                                 is_last_c,
  input  logic                                 is_last_w,
  input  logic [2:0]                           req_size,
  input  logic [cdp_rdma_ig_pkg::addr_w-1:0]   base_addr,
  input  logic [cdp_rdma_ig_pkg::stride_w-1:0] line_stride,
  input  logic [cdp_rdma_ig_pkg::stride_w-1:0] surf_stride,
  output logic [cdp_rdma_ig_pkg::addr_w-1:0]   req_addr
);

  logic [cdp_rdma_ig_pkg::addr_w-1:0] line_base;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] grp_base;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] line_next;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] grp_next;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] chn_next;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] grp_step;
  logic [3:0]                         grp_atoms;

  // ==============================
  // next address candidates
  // ==============================
  // atoms in the current group, 1..8
  assign grp_atoms = {1'b0, req_size} + 4'd1;
  // group length in bytes
  assign grp_step  = {{(cdp_rdma_ig_pkg::addr_w-4-cdp_rdma_ig_pkg::atom_log2){1'b0}},
                      grp_atoms, {cdp_rdma_ig_pkg::atom_log2{1'b0}}};

  // one line down
  assign line_next = line_base
                   + {{(cdp_rdma_ig_pkg::addr_w-cdp_rdma_ig_pkg::stride_w){1'b0}}, line_stride};
  // next width group on the same line
  assign grp_next  = grp_base + grp_step;
  // next channel block, one surface further
  assign chn_next  = req_addr
                   + {{(cdp_rdma_ig_pkg::addr_w-cdp_rdma_ig_pkg::stride_w){1'b0}}, surf_stride};

  // ==============================
  // address registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      line_base <= '0;
      grp_base  <= '0;
      req_addr  <= '0;
    end else if (op_load) begin
      // layer start, all three on the cube base
      line_base <= base_addr;
      grp_base  <= base_addr;
      req_addr  <= base_addr;
    end else if (accept) begin
      if (!is_last_c) begin
        req_addr <= chn_next;
      end else if (!is_last_w) begin
        // back to the top surface, next group
        grp_base <= grp_next;
        req_addr <= grp_next;
      end else begin
        // slice done, start of the next line
        line_base <= line_next;
        grp_base  <= line_next;
        req_addr  <= line_next;
      end
    end
  end

endmodule

// File: hdl/cdp_rdma_req_issue.sv
// joined request/context handshake, request payload and context entry packing
module cdp_rdma_req_issue (
  input  logic                                 run,
  input  logic [cdp_rdma_ig_pkg::addr_w-1:0]   req_addr,
  input  logic [2:0]                           req_size,
  input  logic                                 is_last_w,
  input  logic                                 is_last_h,
  input  logic                                 is_last_c,
  input  logic                                 dma_req_ready,
  input  logic                                 cq_wr_ready,
  output logic                                 dma_req_valid,
  output logic [cdp_rdma_ig_pkg::req_pd_w-1:0] dma_req_pd,
  output logic                                 cq_wr_valid,
  output logic [cdp_rdma_ig_pkg::cq_pd_w-1:0]  cq_wr_pd,
  output logic                                 accept
);

  // ==============================
  // joined handshake
  // ==============================
  // each valid waits on the other side's ready
  assign dma_req_valid = run & cq_wr_ready;
  assign cq_wr_valid   = run & dma_req_ready;
  // both fire together or not at all
  assign accept        = dma_req_valid & dma_req_ready;

  // ==============================
  // payloads
  // ==============================
  // size above the address, zero extended
  assign dma_req_pd = {{(cdp_rdma_ig_pkg::size_w-3){1'b0}}, req_size, req_addr};

  // context entry for the egress side
  always_comb begin
    cq_wr_pd = '0;
    cq_wr_pd[cdp_rdma_ig_pkg::cq_size_lsb +: 3]  = req_size;
    cq_wr_pd[cdp_rdma_ig_pkg::cq_last_w_bit]     = is_last_w;
    cq_wr_pd[cdp_rdma_ig_pkg::cq_last_h_bit]     = is_last_h;
    cq_wr_pd[cdp_rdma_ig_pkg::cq_last_c_bit]     = is_last_c;
  end

endmodule

// File: hdl/cdp_rdma_stall_perf.sv
// read-stall counter and the two alternating per-layer performance registers
module cdp_rdma_stall_perf (
  input  logic                               nvdla_core_clk,
  input  logic                               nvdla_core_rstn,
  input  logic                               dma_en,
  input  logic                               dma_req_valid,
  input  logic                               dma_req_ready,
  input  logic                               layer_end,
  output logic [cdp_rdma_ig_pkg::perf_w-1:0] perf_read_stall_d0,
  output logic [cdp_rdma_ig_pkg::perf_w-1:0] perf_read_stall_d1
);

  logic [cdp_rdma_ig_pkg::perf_w-1:0] stall_cnt;
  logic                               layer_flag;
  logic                               stall;

  // ==============================
  // stall counter
  // ==============================
  // request offered but memory side not taking it
  assign stall = dma_en & dma_req_valid & ~dma_req_ready;

  // layer_end is an accept, so it never meets a stall cycle
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (layer_end) begin
      stall_cnt <= '0;
    end else if (stall) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  // ==============================
  // per-layer result registers
  // ==============================
  // toggles each layer, picks d0 or d1
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag <= 1'b0;
    end else if (layer_end) begin
      layer_flag <= ~layer_flag;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      perf_read_stall_d0 <= '0;
      perf_read_stall_d1 <= '0;
    end else if (layer_end) begin
      if (layer_flag) begin
        perf_read_stall_d1 <= stall_cnt;
      end else begin
        perf_read_stall_d0 <= stall_cnt;
      end
    end
  end

endmodule

// File: hdl/cdp_rdma_ig.sv
// read DMA ingress top: cube walker, address generator, request issue, stall monitor
module cdp_rdma_ig (
  input  logic                                 nvdla_core_clk,
  input  logic                                 nvdla_core_rstn,
  input  logic                                 op_en,
  input  logic                                 dma_en,
  input  logic                                 eg2ig_done,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    width,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    height,
  input  logic [cdp_rdma_ig_pkg::dim_w-1:0]    channel,
  input  logic [31:0]                          base_addr_high,
  input  logic [31:0]                          base_addr_low,
  input  logic [cdp_rdma_ig_pkg::stride_w-1:0] line_stride,
  input  logic [cdp_rdma_ig_pkg::stride_w-1:0] surf_stride,
  output logic                                 dma_req_valid,
  input  logic                                 dma_req_ready,
  output logic [cdp_rdma_ig_pkg::req_pd_w-1:0] dma_req_pd,
  output logic                                 cq_wr_valid,
  input  logic                                 cq_wr_ready,
  output logic [cdp_rdma_ig_pkg::cq_pd_w-1:0]  cq_wr_pd,
  output logic [cdp_rdma_ig_pkg::perf_w-1:0]   perf_read_stall_d0,
  output logic [cdp_rdma_ig_pkg::perf_w-1:0]   perf_read_stall_d1
);

  logic [cdp_rdma_ig_pkg::addr_w-1:0] base_addr;
  logic [cdp_rdma_ig_pkg::addr_w-1:0] req_addr;
  logic [2:0]                         req_size;
  logic                               run;
  logic                               op_load;
  logic                               is_last_w;
  logic                               is_last_h;
  logic                               is_last_c;
  logic                               accept;
  logic                               layer_end;

  // 64-bit cube base from the two register halves
  assign base_addr = {base_addr_high, base_addr_low};

  // ==============================
  // walker and address side by side
  // ==============================
  cdp_rdma_cube_walker u_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_en           (op_en),
    .eg2ig_done      (eg2ig_done),
    .width           (width),
    .height          (height),
    .channel         (channel),
    .accept          (accept),
    .run             (run),
    .op_load         (op_load),
    .is_last_w       (is_last_w),
    .is_last_h       (is_last_h),
    .is_last_c       (is_last_c),
    .req_size        (req_size),
    .layer_end       (layer_end)
  );

  cdp_rdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .accept          (accept),
    .is_last_c       (is_last_c),
    .is_last_w       (is_last_w),
    .req_size        (req_size),
    .base_addr       (base_addr),
    .line_stride     (line_stride),
    .surf_stride     (surf_stride),
    .req_addr        (req_addr)
  );

  // ==============================
  // outgoing transfers and stall monitor
  // ==============================
  cdp_rdma_req_issue u_req_issue (
    .run           (run),
    .req_addr      (req_addr),
    .req_size      (req_size),
    .is_last_w     (is_last_w),
    .is_last_h     (is_last_h),
    .is_last_c     (is_last_c),
    .dma_req_ready (dma_req_ready),
    .cq_wr_ready   (cq_wr_ready),
    .dma_req_valid (dma_req_valid),
    .dma_req_pd    (dma_req_pd),
    .cq_wr_valid   (cq_wr_valid),
    .cq_wr_pd      (cq_wr_pd),
    .accept        (accept)
  );

  // watches the request channel only
  cdp_rdma_stall_perf u_stall_perf (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .dma_en             (dma_en),
    .dma_req_valid      (dma_req_valid),
    .dma_req_ready      (dma_req_ready),
    .layer_end          (layer_end),
    .perf_read_stall_d0 (perf_read_stall_d0),
    .perf_read_stall_d1 (perf_read_stall_d1)
  );

endmodule

// File: verification/cdp_rdma_ig_chk.sv
// bound checker: quiet valids after reset and layer end, joined handshake, payload hold
module cdp_rdma_ig_chk (
  input logic                                 nvdla_core_clk,
  input logic                                 nvdla_core_rstn,
  input logic                                 op_en,
  input logic                                 eg2ig_done,
  input logic                                 run,
  input logic                                 layer_end,
  input logic                                 dma_req_valid,
  input logic                                 dma_req_ready,
  input logic [cdp_rdma_ig_pkg::req_pd_w-1:0] dma_req_pd,
  input logic                                 cq_wr_valid,
  input logic                                 cq_wr_ready,
  input logic [cdp_rdma_ig_pkg::cq_pd_w-1:0]  cq_wr_pd
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_cnt = 0;
  logic ended;

  // cube end seen, egress not yet done
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ended <= 1'b0;
    end else if (layer_end) begin
      ended <= 1'b1;
    end else if (eg2ig_done) begin
      ended <= 1'b0;
    end
  end

  // ==============================
  // quiet outside a layer
  // ==============================
  a_reset_quiet: assert property (@(posedge nvdla_core_clk)
    !nvdla_core_rstn |-> !dma_req_valid && !cq_wr_valid)
    else begin
      $error("valid high during reset");
      fail_cnt++;
    end

  a_end_quiet: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    ended |-> !dma_req_valid && !cq_wr_valid)
    else begin
      $error("valid high after cube end before egress done");
      fail_cnt++;
    end

  // a layer only starts from op_en
  a_start_op_en: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(run) |-> $past(op_en))
    else begin
      $error("layer started without op_en");
      fail_cnt++;
    end

  // ==============================
  // joined handshake and hold
  // ==============================
  a_joined: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_req_valid && dma_req_ready) == (cq_wr_valid && cq_wr_ready))
    else begin
      $error("request and context transfers not taken together");
      fail_cnt++;
    end

  a_req_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_req_valid && !dma_req_ready |=> $stable(dma_req_pd))
    else begin
      $error("request payload changed while stalled");
      fail_cnt++;
    end

  a_cq_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    cq_wr_valid && !cq_wr_ready |=> $stable(cq_wr_pd))
    else begin
      $error("context entry changed while stalled");
      fail_cnt++;
    end

endmodule

bind cdp_rdma_ig cdp_rdma_ig_chk u_chk (
  .nvdla_core_clk (nvdla_core_clk),
  .nvdla_core_rstn(nvdla_core_rstn),
  .op_en          (op_en),
  .eg2ig_done     (eg2ig_done),
  .run            (run),
  .layer_end      (layer_end),
  .dma_req_valid  (dma_req_valid),
  .dma_req_ready  (dma_req_ready),
  .dma_req_pd     (dma_req_pd),
  .cq_wr_valid    (cq_wr_valid),
  .cq_wr_ready    (cq_wr_ready),
  .cq_wr_pd       (cq_wr_pd)
);

// File: verification/cdp_rdma_ig_tb.sv
// testbench: clock, reset, random back-pressure, cube model, per-test report and watchdog
module cdp_rdma_ig_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // ==============================
  // cubes, fields are size minus one
  // ==============================
  localparam int n_cubes = 8;
  localparam int cube_w [n_cubes] = '{19, 5, 15, 40, 19, 27, 27, 27};
  localparam int cube_h [n_cubes] = '{2, 1, 0, 2, 3, 1, 1, 1};
  localparam int cube_c [n_cubes] = '{63, 31, 95, 40, 70, 63, 63, 63};
  localparam logic [31:0] ls_val = 32'h0001_0000;
  localparam logic [31:0] ss_val = 32'h0000_2000;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        op_en, dma_en, eg2ig_done;
  logic [12:0] width, height, channel;
  logic [31:0] base_addr_high, base_addr_low, line_stride, surf_stride;
  logic        dma_req_valid, dma_req_ready, cq_wr_valid, cq_wr_ready;
  logic [cdp_rdma_ig_pkg::req_pd_w-1:0] dma_req_pd;
  logic [cdp_rdma_ig_pkg::cq_pd_w-1:0]  cq_wr_pd;
  logic [cdp_rdma_ig_pkg::perf_w-1:0]   perf_read_stall_d0, perf_read_stall_d1;

  logic [63:0] exp_addr [$];
  logic [5:0]  exp_cq [$];
  int unsigned exp_perf [2];
  bit          perf_sel;
  logic        rand_ready;
  logic [31:0] rng = 32'd93429;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          accept_cnt = 0;

  cdp_rdma_ig uut (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #4 nvdla_core_clk = ~nvdla_core_clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // requests per cube, lines x groups x channel blocks
  function automatic int cube_reqs(input int w, input int h, input int c);
    return (h + 1) * ((w + 8) / 8) * (c / 32 + 1);
  endfunction

  function automatic int total_errors();
    return err_cnt + uut.u_chk.fail_cnt;
  endfunction

  // back-pressure, about three in four cycles ready per side
  always @(posedge nvdla_core_clk) begin
    if (rand_ready) begin
      rng = next_rand(rng);
      dma_req_ready <= |rng[1:0];
      cq_wr_ready   <= |rng[5:4];
    end else begin
      dma_req_ready <= 1'b1;
      cq_wr_ready   <= 1'b1;
    end
  end

  // ==============================
  // cube model, C inside W inside H
  // ==============================
  task automatic build_model(input int w, input int h, input int c, input logic [63:0] base);
    int          ngrp;
    logic [63:0] grp_off;
    logic [2:0]  sz;
    ngrp = (w + 8) / 8;
    exp_addr.delete();
    exp_cq.delete();
    for (int y = 0; y <= h; y++) begin
      grp_off = '0;
      for (int g = 0; g < ngrp; g++) begin
        // full groups of eight, remainder in the last one
        sz = (g == ngrp - 1) ? w[2:0] : 3'd7;
        for (int k = 0; k <= c / 32; k++) begin
          exp_addr.push_back(base + 64'(y) * 64'(ls_val) + grp_off + 64'(k) * 64'(ss_val));
          exp_cq.push_back({k == c / 32, y == h, g == ngrp - 1, sz});
        end
        grp_off = grp_off + ((64'(sz) + 64'd1) << cdp_rdma_ig_pkg::atom_log2);
      end
    end
  endtask

  task automatic check_accept(input logic [63:0] ea, input logic [5:0] eq);
    accept_cnt++;
    assert (cq_wr_valid && cq_wr_ready) else begin
      $display("error at %0t: request accepted without its context entry", $time);
      err_cnt++;
    end
    assert (dma_req_pd[cdp_rdma_ig_pkg::addr_w-1:0] === ea &&
            dma_req_pd[cdp_rdma_ig_pkg::addr_w +: cdp_rdma_ig_pkg::size_w] === 15'(eq[2:0]))
    else begin
      $display("error at %0t: request %h, expected addr %h size %0d", $time, dma_req_pd, ea,
               eq[2:0]);
      err_cnt++;
    end
    assert (cq_wr_pd === eq) else begin
      $display("error at %0t: context entry %b, expected %b", $time, cq_wr_pd, eq);
      err_cnt++;
    end
    // cube end carries all three last bits
    assert (exp_addr.size() != 0 || cq_wr_pd[5:3] === 3'b111) else begin
      $display("error at %0t: cube end without all last bits", $time);
      err_cnt++;
    end
  endtask

  task automatic run_layer(input int idx, input logic [63:0] base, input logic en,
                           input logic back_to_back);
    int unsigned stalls;
    logic        first;
    build_model(cube_w[idx], cube_h[idx], cube_c[idx], base);
    stalls = 0;
    first  = 1'b1;
    @(posedge nvdla_core_clk);
    width          <= 13'(cube_w[idx]);
    height         <= 13'(cube_h[idx]);
    channel        <= 13'(cube_c[idx]);
    base_addr_high <= base[63:32];
    base_addr_low  <= base[31:0];
    dma_en         <= en;
    op_en          <= 1'b1;
    @(posedge nvdla_core_clk);
    op_en <= 1'b0;
    while (exp_addr.size() > 0) begin
      @(negedge nvdla_core_clk);
      // both sinks ready, one request per cycle from the first one on
      if (back_to_back) begin
        assert (dma_req_valid) else begin
          if (first) begin
            $display("error at %0t: no request one cycle after op_en", $time);
          end else begin
            $display("error at %0t: gap between requests with both sinks ready", $time);
          end
          err_cnt++;
        end
      end
      first = 1'b0;
      // request offered while the memory side holds off
      if (en && cq_wr_ready && !dma_req_ready) begin
        stalls++;
      end
      if (dma_req_valid && dma_req_ready) begin
        check_accept(exp_addr.pop_front(), exp_cq.pop_front());
      end
    end
    // results land on the cube-end edge
    @(posedge nvdla_core_clk);
    exp_perf[perf_sel] = stalls;
    perf_sel = ~perf_sel;
    @(negedge nvdla_core_clk);
    assert (perf_read_stall_d0 === exp_perf[0] && perf_read_stall_d1 === exp_perf[1]) else begin
      $display("error at %0t: stall regs %0d/%0d, expected %0d/%0d", $time, perf_read_stall_d0,
               perf_read_stall_d1, exp_perf[0], exp_perf[1]);
      err_cnt++;
    end
    repeat (3) @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b1;
    @(posedge nvdla_core_clk);
    eg2ig_done <= 1'b0;
  endtask

  task automatic reset_dut();
    @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b0;
    repeat (16) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    exp_perf[0] = 0;
    exp_perf[1] = 0;
    perf_sel    = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail", tests_run, name);
    end
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    int e;
    nvdla_core_rstn = 1'b0;
    {op_en, dma_en, eg2ig_done} = 3'b000;
    {width, height, channel} = '0;
    {base_addr_high, base_addr_low} = '0;
    line_stride   = ls_val;
    surf_stride   = ss_val;
    dma_req_ready = 1'b1;
    cq_wr_ready   = 1'b1;
    rand_ready    = 1'b0;
    reset_dut();
    e = total_errors();
    repeat (4) begin
      @(negedge nvdla_core_clk);
      assert (!dma_req_valid && !cq_wr_valid) else begin
        $display("error at %0t: valid high before op_en", $time);
        err_cnt++;
      end
    end
    report_test("quiet_after_reset", e);
    e = total_errors();
    run_layer(0, 64'h0000_0012_3400_0000, 1'b1, 1'b1);
    report_test("walk_always_ready", e);
    e = total_errors();
    for (int i = 1; i <= 3; i++) begin
      run_layer(i, 64'h0000_0001_0000_0000 + (64'(i) << 20), 1'b1, 1'b1);
    end
    report_test("context_entries", e);
    e = total_errors();
    @(posedge nvdla_core_clk);
    rand_ready <= 1'b1;
    run_layer(4, 64'h0000_0040_0000_0100, 1'b1, 1'b0);
    report_test("back_pressure", e);
    e = total_errors();
    // fresh reset so the first layer lands in d0
    reset_dut();
    run_layer(5, 64'h0000_0000_2000_0000, 1'b1, 1'b0);
    run_layer(6, 64'h0000_0000_3000_0000, 1'b1, 1'b0);
    run_layer(7, 64'h0000_0000_4000_0000, 1'b0, 1'b0);
    report_test("stall_perf", e);
    $display("tests %0d, failed %0d, accepts %0d, errors %0d", tests_run, tests_failed,
             accept_cnt, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog, twenty cycles per request of all cubes
  initial begin
    int limit;
    limit = 0;
    for (int i = 0; i < n_cubes; i++) begin
      limit += cube_reqs(cube_w[i], cube_h[i], cube_c[i]);
    end
    limit = limit * 20;
    repeat (limit) @(posedge nvdla_core_clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sources.f
hdl/cdp_rdma_ig_pkg.sv
hdl/cdp_rdma_cube_walker.sv
hdl/cdp_rdma_addr_gen.sv
hdl/cdp_rdma_req_issue.sv
hdl/cdp_rdma_stall_perf.sv
hdl/cdp_rdma_ig.sv
verification/cdp_rdma_ig_chk.sv
verification/cdp_rdma_ig_tb.sv

// File: Makefile
TOP = cdp_rdma_ig_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	verilator --lint-only -Wall --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
